//--- common/ppu_geom_pkg.sv
package ppu_geom_pkg;

    // Sprite table and per-line limits
    localparam int num_sprites = 16;
    localparam int num_slots   = 8;    // Sprites shown on one line
    localparam int sprite_size = 16;   // Width and height in pixels

    // VGA counter widths
    localparam int hcount_w = 11;
    localparam int vcount_w = 10;

    // Sprite coordinates as stored in the OAM
    localparam int coord_w = 16;

    // Pixel and graphics row format
    localparam int pixel_w = 2;
    localparam int row_w   = 32;       // 16 pixels of 2 bits

    // Colour output and palette size
    localparam int color_w    = 24;
    localparam int num_colors = 8;     // Two palettes of four entries

    // Derived index widths
    localparam int sprite_idx_w = $clog2(num_sprites);
    localparam int slot_idx_w   = $clog2(num_slots);
    localparam int row_sel_w    = $clog2(sprite_size);

endpackage

//--- common/ppu_mem_pkg.sv
package ppu_mem_pkg;

    // External memory address widths
    localparam int oam_addr_w = 5;
    localparam int gfx_addr_w = 11;
    localparam int pal_addr_w = 3;
    localparam int tile_id_w  = 7;

    // Two OAM words per sprite
    localparam int oam_words = 32;

    // Even word fields
    localparam int oam_tile_lsb  = 0;
    localparam int oam_pal_bit   = 7;
    localparam int oam_hflip_bit = 30;
    localparam int oam_vflip_bit = 31;

    // Odd word fields
    localparam int oam_x_lsb = 0;
    localparam int oam_y_lsb = 16;

    // Line builder FSM
    typedef enum logic [2:0] {
        idle,
        scan,
        fetch,
        load,
        done
    } build_state_t;

endpackage

//--- sprite_engine/oam_cache.sv
`timescale 1ns/1ps

module oam_cache (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  vblank,
    input  logic [ppu_geom_pkg::row_w-1:0]        oam_rdata,
    output logic [ppu_mem_pkg::oam_addr_w-1:0]    oam_addr,
    output logic [ppu_geom_pkg::coord_w-1:0]      sprite_x [ppu_geom_pkg::num_sprites],
    output logic [ppu_geom_pkg::coord_w-1:0]      sprite_y [ppu_geom_pkg::num_sprites],
    output logic [ppu_mem_pkg::tile_id_w-1:0]     sprite_tile [ppu_geom_pkg::num_sprites],
    output logic [ppu_geom_pkg::num_sprites-1:0]  sprite_pal,
    output logic [ppu_geom_pkg::num_sprites-1:0]  sprite_hflip,
    output logic [ppu_geom_pkg::num_sprites-1:0]  sprite_vflip
);
    import ppu_geom_pkg::*;
    import ppu_mem_pkg::*;

    logic [oam_addr_w:0]      ptr;       // Next word to request, stops at oam_words
    logic [oam_addr_w-1:0]    rd_idx;    // Word whose data returns this cycle
    logic                     rd_valid;
    logic [sprite_idx_w-1:0]  rd_sprite;

    assign rd_sprite = rd_idx[oam_addr_w-1:1];

    // Read sequence, one address per cycle while vblank is high
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr      <= '0;
            oam_addr <= '0;
            rd_valid <= 1'b0;
        end else if (vblank) begin
            rd_valid <= (ptr < oam_words);
            rd_idx   <= ptr[oam_addr_w-1:0];
            if (ptr < oam_words) begin
                oam_addr <= ptr[oam_addr_w-1:0];
                ptr      <= ptr + 1'b1;
            end else begin
                oam_addr <= '0;                  // Sequence finished
            end
        end else begin
            ptr      <= '0;
            oam_addr <= '0;
            rd_valid <= 1'b0;
        end
    end

    // Word parity selects which attribute fields are in the returned data
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            if (rd_idx[0]) begin
                sprite_x[rd_sprite] <= oam_rdata[oam_x_lsb +: coord_w];
                sprite_y[rd_sprite] <= oam_rdata[oam_y_lsb +: coord_w];
            end else begin
                sprite_tile[rd_sprite]  <= oam_rdata[oam_tile_lsb +: tile_id_w];
                sprite_pal[rd_sprite]   <= oam_rdata[oam_pal_bit];
                sprite_hflip[rd_sprite] <= oam_rdata[oam_hflip_bit];
                sprite_vflip[rd_sprite] <= oam_rdata[oam_vflip_bit];
            end
        end
    end

endmodule

//--- sprite_engine/line_builder.sv
`timescale 1ns/1ps

module line_builder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hsync,
    input  logic [ppu_geom_pkg::vcount_w-1:0]     vcount,
    input  logic [ppu_geom_pkg::coord_w-1:0]      sprite_x [ppu_geom_pkg::num_sprites],
    input  logic [ppu_geom_pkg::coord_w-1:0]      sprite_y [ppu_geom_pkg::num_sprites],
    input  logic [ppu_mem_pkg::tile_id_w-1:0]     sprite_tile [ppu_geom_pkg::num_sprites],
    input  logic [ppu_geom_pkg::num_sprites-1:0]  sprite_pal,
    input  logic [ppu_geom_pkg::num_sprites-1:0]  sprite_hflip,
    input  logic [ppu_geom_pkg::num_sprites-1:0]  sprite_vflip,
    input  logic [ppu_geom_pkg::row_w-1:0]        gfx_rdata,
    output logic [ppu_mem_pkg::gfx_addr_w-1:0]    gfx_addr,
    output logic                                  slot_load,
    output logic [ppu_geom_pkg::row_w-1:0]        slot_row [ppu_geom_pkg::num_slots],
    output logic [ppu_geom_pkg::coord_w-1:0]      slot_x [ppu_geom_pkg::num_slots],
    output logic [ppu_geom_pkg::num_slots-1:0]    slot_pal
);
    import ppu_geom_pkg::*;
    import ppu_mem_pkg::*;

    build_state_t             state;
    logic [sprite_idx_w-1:0]  scan_idx;
    logic [slot_idx_w:0]      found;      // Sprites recorded so far, up to num_slots
    logic [slot_idx_w:0]      fetch_idx;  // Slot whose address goes out this cycle
    logic [sprite_idx_w-1:0]  slot_sprite [num_slots];
    logic [coord_w:0]         vpos;
    logic [coord_w:0]         y_top;
    logic [coord_w:0]         y_end;
    logic                     hit;
    logic [slot_idx_w-1:0]    addr_slot;
    logic [slot_idx_w-1:0]    cap_slot;
    logic [sprite_idx_w-1:0]  addr_sprite;
    logic [sprite_idx_w-1:0]  cap_sprite;
    logic                     addr_used;
    logic                     cap_used;
    logic [coord_w-1:0]       dy;
    logic [row_sel_w-1:0]     row_sel;

    // Pixel order reversal, each 2-bit pixel stays intact
    function automatic logic [row_w-1:0] reverse_pixels(input logic [row_w-1:0] r);
        logic [row_w-1:0] f;
        for (int i = 0; i < sprite_size; i++) begin
            f[i*pixel_w +: pixel_w] = r[(sprite_size-1-i)*pixel_w +: pixel_w];
        end
        return f;
    endfunction

    // Vertical hit test for the sprite being scanned
    assign vpos  = (coord_w + 1)'(vcount);
    assign y_top = {1'b0, sprite_y[scan_idx]};
    assign y_end = y_top + (coord_w + 1)'(sprite_size);
    assign hit   = (vpos >= y_top) && (vpos < y_end);

    // Fetch pipeline, data for the previous slot returns while the next address goes out
    assign addr_slot   = fetch_idx[slot_idx_w-1:0];
    assign cap_slot    = addr_slot - 1'b1;
    assign addr_sprite = slot_sprite[addr_slot];
    assign cap_sprite  = slot_sprite[cap_slot];
    assign addr_used   = ({1'b0, addr_slot} < found);
    assign cap_used    = ({1'b0, cap_slot} < found);

    assign dy      = coord_w'(vcount) - sprite_y[addr_sprite];
    assign row_sel = sprite_vflip[addr_sprite] ? ~dy[row_sel_w-1:0]   // 15 - row
                                               : dy[row_sel_w-1:0];

    assign slot_load = (state == load);

    always_ff @(posedge clk) begin
        if (reset || !hsync) begin
            state     <= idle;
            scan_idx  <= '0;
            found     <= '0;
            fetch_idx <= '0;
            gfx_addr  <= '0;
        end else begin
            case (state)
                idle: begin
                    state    <= scan;
                    scan_idx <= '0;
                    found    <= '0;
                end
                scan: begin
                    if (hit && found < num_slots) begin
                        slot_sprite[found[slot_idx_w-1:0]] <= scan_idx;
                        slot_x[found[slot_idx_w-1:0]]      <= sprite_x[scan_idx];
                        slot_pal[found[slot_idx_w-1:0]]    <= sprite_pal[scan_idx];
                        found <= found + 1'b1;
                    end
                    if (scan_idx == sprite_idx_w'(num_sprites - 1)) begin
                        state     <= fetch;
                        fetch_idx <= '0;
                    end
                    scan_idx <= scan_idx + 1'b1;
                end
                fetch: begin
                    if (fetch_idx < num_slots) begin
                        // Empty slots leave the address at 0
                        gfx_addr <= addr_used ? {sprite_tile[addr_sprite], row_sel} : '0;
                    end else begin
                        gfx_addr <= '0;
                        state    <= load;
                    end
                    if (fetch_idx != '0) begin
                        if (!cap_used)
                            slot_row[cap_slot] <= '0;
                        else if (sprite_hflip[cap_sprite])
                            slot_row[cap_slot] <= reverse_pixels(gfx_rdata);
                        else
                            slot_row[cap_slot] <= gfx_rdata;
                    end
                    fetch_idx <= fetch_idx + 1'b1;
                end
                load: state <= done;                   // One cycle of slot_load
                done: state <= done;                   // Wait for hsync to drop
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- sprite_engine/sprite_slot.sv
`timescale 1ns/1ps

module sprite_slot (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               active,
    input  logic [ppu_geom_pkg::hcount_w-1:0]  hcount,
    input  logic                               load,
    input  logic [ppu_geom_pkg::row_w-1:0]     row,
    input  logic [ppu_geom_pkg::coord_w-1:0]   x,
    input  logic                               pal,
    output logic [ppu_geom_pkg::pixel_w-1:0]   pixel,
    output logic                               pixel_pal
);
    import ppu_geom_pkg::*;

    logic [row_w-1:0]    shift_row;
    logic [coord_w-1:0]  x_r;
    logic                pal_r;
    logic [coord_w:0]    hpos;
    logic [coord_w:0]    x_end;
    logic                in_range;

    assign hpos     = (coord_w + 1)'(hcount);
    assign x_end    = {1'b0, x_r} + (coord_w + 1)'(sprite_size);
    assign in_range = (hpos >= {1'b0, x_r}) && (hpos < x_end);

    always_ff @(posedge clk) begin
        if (load) begin
            x_r   <= x;
            pal_r <= pal;
        end
    end

    // Leading pixel sits in the top bits of the row
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_row <= '0;
            pixel     <= '0;
        end else if (load) begin
            shift_row <= row;
            pixel     <= '0;
        end else if (active && in_range) begin
            pixel     <= shift_row[row_w-1 -: pixel_w];
            shift_row <= shift_row << pixel_w;
        end else begin
            pixel <= '0;                               // Transparent outside the sprite
        end
    end

    assign pixel_pal = pal_r;

endmodule

//--- rtl/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                vblank,
    input  logic [ppu_geom_pkg::color_w-1:0]    pal_rdata,
    output logic [ppu_mem_pkg::pal_addr_w-1:0]  pal_addr,
    input  logic [ppu_geom_pkg::pixel_w-1:0]    slot_pixel [ppu_geom_pkg::num_slots],
    input  logic [ppu_geom_pkg::num_slots-1:0]  slot_pal,
    output logic [ppu_geom_pkg::color_w-1:0]    pixel_color
);
    import ppu_geom_pkg::*;
    import ppu_mem_pkg::*;

    logic [color_w-1:0]     palette [num_colors];
    logic [pal_addr_w:0]    pal_ptr;
    logic [pal_addr_w-1:0]  rd_idx;
    logic                   rd_valid;
    logic [pixel_w-1:0]     sel_pix;
    logic                   sel_pal;
    logic [pal_addr_w-1:0]  color_idx;

    // Palette copy, same one-cycle read pattern as the OAM
    always_ff @(posedge clk) begin
        if (reset) begin
            pal_ptr  <= '0;
            pal_addr <= '0;
            rd_valid <= 1'b0;
        end else if (vblank) begin
            rd_valid <= (pal_ptr < num_colors);
            rd_idx   <= pal_ptr[pal_addr_w-1:0];
            if (pal_ptr < num_colors) begin
                pal_addr <= pal_ptr[pal_addr_w-1:0];
                pal_ptr  <= pal_ptr + 1'b1;
            end else begin
                pal_addr <= '0;
            end
        end else begin
            pal_ptr  <= '0;
            pal_addr <= '0;
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) palette[rd_idx] <= pal_rdata;
    end

    // Walk down from the top slot so the lowest opaque slot is assigned last
    always_comb begin
        sel_pix = '0;
        sel_pal = 1'b0;
        for (int s = num_slots - 1; s >= 0; s--) begin
            if (slot_pixel[s] != '0) begin
                sel_pix = slot_pixel[s];
                sel_pal = slot_pal[s];
            end
        end
    end

    assign color_idx = {sel_pal, sel_pix};             // pixel + 4 * pal

    always_ff @(posedge clk) begin
        if (reset) pixel_color <= '0;
        else       pixel_color <= palette[color_idx];
    end

endmodule

//--- rtl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [ppu_geom_pkg::hcount_w-1:0]   hcount,
    input  logic [ppu_geom_pkg::vcount_w-1:0]   vcount,
    input  logic                                vblank,
    input  logic                                hsync,
    input  logic [ppu_geom_pkg::row_w-1:0]      oam_rdata,
    input  logic [ppu_geom_pkg::row_w-1:0]      gfx_rdata,
    input  logic [ppu_geom_pkg::color_w-1:0]    pal_rdata,
    output logic [ppu_mem_pkg::oam_addr_w-1:0]  oam_addr,
    output logic [ppu_mem_pkg::gfx_addr_w-1:0]  gfx_addr,
    output logic [ppu_mem_pkg::pal_addr_w-1:0]  pal_addr,
    output logic [ppu_geom_pkg::color_w-1:0]    pixel_color
);
    import ppu_geom_pkg::*;
    import ppu_mem_pkg::*;

    // Attributes cached during vblank
    logic [coord_w-1:0]    sprite_x [num_sprites];
    logic [coord_w-1:0]    sprite_y [num_sprites];
    logic [tile_id_w-1:0]  sprite_tile [num_sprites];
    logic [num_sprites-1:0] sprite_pal;
    logic [num_sprites-1:0] sprite_hflip;
    logic [num_sprites-1:0] sprite_vflip;

    // Per-line slot data
    logic                  slot_load;
    logic [row_w-1:0]      slot_row [num_slots];
    logic [coord_w-1:0]    slot_x [num_slots];
    logic [num_slots-1:0]  slot_pal;
    logic [pixel_w-1:0]    slot_pixel [num_slots];
    logic [num_slots-1:0]  slot_pixel_pal;
    logic                  active;

    assign active = !vblank && !hsync;                 // Visible part of the line

    oam_cache i_oam_cache (
        .clk, .reset, .vblank, .oam_rdata, .oam_addr,
        .sprite_x, .sprite_y, .sprite_tile,
        .sprite_pal, .sprite_hflip, .sprite_vflip
    );

    line_builder i_line_builder (
        .clk, .reset, .hsync, .vcount,
        .sprite_x, .sprite_y, .sprite_tile,
        .sprite_pal, .sprite_hflip, .sprite_vflip,
        .gfx_rdata, .gfx_addr,
        .slot_load, .slot_row, .slot_x, .slot_pal
    );

    for (genvar s = 0; s < num_slots; s++) begin : g_slot
        sprite_slot i_sprite_slot (
            .clk       (clk),
            .reset     (reset),
            .active    (active),
            .hcount    (hcount),
            .load      (slot_load),
            .row       (slot_row[s]),
            .x         (slot_x[s]),
            .pal       (slot_pal[s]),
            .pixel     (slot_pixel[s]),
            .pixel_pal (slot_pixel_pal[s])
        );
    end

    pixel_mixer i_pixel_mixer (
        .clk, .reset, .vblank, .pal_rdata, .pal_addr,
        .slot_pixel,
        .slot_pal    (slot_pixel_pal),
        .pixel_color
    );

endmodule

//--- test/ppu_chk.sv
`timescale 1ns/1ps

module ppu_chk (
    input logic                                clk,
    input logic                                reset,
    input logic                                vblank,
    input logic                                hsync,
    input logic [ppu_mem_pkg::oam_addr_w-1:0]  oam_addr,
    input logic [ppu_mem_pkg::gfx_addr_w-1:0]  gfx_addr,
    input logic                                slot_load,
    input ppu_mem_pkg::build_state_t           state
);
    import ppu_mem_pkg::*;

    logic [5:0]             vb_cnt;    // Vblank cycles seen so far, saturates
    logic [oam_addr_w-1:0]  oam_exp;

    always_ff @(posedge clk) begin
        if (reset || !vblank) vb_cnt <= '0;
        else if (vb_cnt != '1) vb_cnt <= vb_cnt + 1'b1;
    end

    // Address issued one cycle back, 0 before and after the sweep
    assign oam_exp = (vb_cnt == '0 || vb_cnt > oam_words) ? '0
                                                          : oam_addr_w'(vb_cnt - 1'b1);

    reset_clears: assert property (@(posedge clk)
        reset |=> (oam_addr == '0 && gfx_addr == '0 && !slot_load && state == idle))
        else $error("Address, slot load or builder state not cleared by reset");

    oam_sweep: assert property (@(posedge clk) disable iff (reset) oam_addr == oam_exp)
        else $error("oam_addr left its vblank sequence, got %h expected %h", oam_addr, oam_exp);

    load_in_hsync: assert property (@(posedge clk) disable iff (reset) slot_load |-> hsync)
        else $error("slot_load seen outside hsync");

    load_single: assert property (@(posedge clk) disable iff (reset) slot_load |=> !slot_load)
        else $error("slot_load held for more than one cycle");

    // Scan of 16 sprites, 9 fetch cycles, one idle cycle
    load_timing: assert property (@(posedge clk) disable iff (reset)
        $rose(hsync) |-> ##26 slot_load)
        else $error("slot_load did not come 26 cycles after hsync rose");

endmodule

//--- test/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;
    import ppu_geom_pkg::*;
    import ppu_mem_pkg::*;

    localparam int vblank_cycles = 40;
    localparam int hsync_cycles  = 32;
    localparam int span          = 64;                 // Active hcount values per line
    localparam int line_cycles   = hsync_cycles + span + 3;
    localparam int num_tests     = 5;
    localparam int num_lines     = 6;
    localparam int run_cycles    = 10 + num_tests * (vblank_cycles + 1) + num_lines * line_cycles;
    localparam longint timeout_ns = longint'(run_cycles) * 10 * 12 / 10;   // 20% margin

    logic                   clk;
    logic                   reset;
    logic [hcount_w-1:0]    hcount;
    logic [vcount_w-1:0]    vcount;
    logic                   vblank;
    logic                   hsync;
    logic [row_w-1:0]       oam_rdata;
    logic [row_w-1:0]       gfx_rdata;
    logic [color_w-1:0]     pal_rdata;
    logic [oam_addr_w-1:0]  oam_addr;
    logic [gfx_addr_w-1:0]  gfx_addr;
    logic [pal_addr_w-1:0]  pal_addr;
    logic [color_w-1:0]     pixel_color;

    logic [row_w-1:0]    oam_mem [oam_words];
    logic [row_w-1:0]    gfx_mem [1 << gfx_addr_w];
    logic [color_w-1:0]  pal_mem [num_colors];

    // Sprite table as the tests set it up
    int  spr_x [num_sprites];
    int  spr_y [num_sprites];
    int  spr_tile [num_sprites];
    bit  spr_pal [num_sprites];
    bit  spr_hflip [num_sprites];
    bit  spr_vflip [num_sprites];

    int checks;
    int errors;
    int test_errors;
    int tests_run;

    ppu_top i_ppu_top (
        .clk, .reset, .hcount, .vcount, .vblank, .hsync,
        .oam_rdata, .gfx_rdata, .pal_rdata,
        .oam_addr, .gfx_addr, .pal_addr, .pixel_color
    );

    // Address registers live in the DUT, so data follows its address by one cycle
    assign oam_rdata = oam_mem[oam_addr];
    assign gfx_rdata = gfx_mem[gfx_addr];
    assign pal_rdata = pal_mem[pal_addr];

    bind oam_cache ppu_chk i_oam_chk (
        .clk, .reset, .vblank, .oam_addr,
        .hsync     (1'b0),
        .gfx_addr  ('0),
        .slot_load (1'b0),
        .state     (ppu_mem_pkg::idle)
    );

    bind line_builder ppu_chk i_builder_chk (
        .clk, .reset, .hsync, .gfx_addr, .slot_load, .state,
        .vblank    (1'b0),
        .oam_addr  ('0)
    );

    always #5 clk = ~clk;

    initial begin
        #(timeout_ns);
        $display("Watchdog expired, the run went past its expected length");
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic clear_sprites();
        for (int n = 0; n < num_sprites; n++) begin
            spr_x[n]     = 0;
            spr_y[n]     = 32768;                          // Far below the screen
            spr_tile[n]  = 0;
            spr_pal[n]   = 1'b0;
            spr_hflip[n] = 1'b0;
            spr_vflip[n] = 1'b0;
        end
    endtask

    task automatic place_sprite(input int n, input int x, input int y, input int tile,
                                input bit pal, input bit hflip, input bit vflip);
        spr_x[n]     = x;
        spr_y[n]     = y;
        spr_tile[n]  = tile;
        spr_pal[n]   = pal;
        spr_hflip[n] = hflip;
        spr_vflip[n] = vflip;
    endtask

    task automatic check_pal_addr(input int cycle, input logic [pal_addr_w-1:0] exp);
        assert (pal_addr == exp) else begin
            $display("CHECK FAILED: pal_addr vblank cycle %0d expected %h got %h",
                     cycle, exp, pal_addr);
            test_errors++;
        end
    endtask

    // Writes OAM words and fresh palette colours, then holds vblank
    task automatic run_vblank();
        logic [pal_addr_w-1:0] exp_pal_addr;
        for (int n = 0; n < num_sprites; n++) begin
            oam_mem[2*n] = {spr_vflip[n], spr_hflip[n], 22'h0, spr_pal[n],
                            tile_id_w'(spr_tile[n])};
            oam_mem[2*n+1] = {coord_w'(spr_y[n]), coord_w'(spr_x[n])};
        end
        for (int i = 0; i < num_colors; i++) pal_mem[i] = color_w'($urandom);
        @(negedge clk);
        check_pal_addr(0, '0);                         // Idle outside vblank
        vblank = 1'b1;
        for (int c = 1; c <= vblank_cycles; c++) begin
            @(negedge clk);
            // Palette entries 0 to 7, one per cycle, then back to 0
            exp_pal_addr = (c <= num_colors) ? pal_addr_w'(c - 1) : '0;
            check_pal_addr(c, exp_pal_addr);
        end
        vblank = 1'b0;
    endtask

    function automatic logic [color_w-1:0] expected_color(input int v, input int h);
        int               hits;
        int               k;
        int               r;
        logic [row_w-1:0] w;
        logic [1:0]       p;
        hits = 0;
        for (int n = 0; n < num_sprites; n++) begin
            if (hits < num_slots && v >= spr_y[n] && v < spr_y[n] + sprite_size) begin
                hits++;
                k = h - spr_x[n];
                if (k >= 0 && k < sprite_size) begin
                    r = spr_vflip[n] ? 15 - (v - spr_y[n]) : v - spr_y[n];
                    w = gfx_mem[spr_tile[n] * 16 + r];
                    p = spr_hflip[n] ? w[2*k +: 2] : w[31 - 2*k -: 2];   // Leftmost pixel on top
                    if (p != 2'b00) return pal_mem[4 * spr_pal[n] + p];
                end
            end
        end
        return pal_mem[0];
    endfunction

    task automatic run_line(input int v);
        int               exp_addr [num_slots];
        bit               seen [num_slots];
        int               used;
        logic [color_w-1:0] exp_color;
        used = 0;
        for (int n = 0; n < num_sprites; n++) begin
            if (used < num_slots && v >= spr_y[n] && v < spr_y[n] + sprite_size) begin
                exp_addr[used] = spr_tile[n] * 16
                               + (spr_vflip[n] ? 15 - (v - spr_y[n]) : v - spr_y[n]);
                seen[used] = 1'b0;
                used++;
            end
        end
        @(negedge clk);
        vcount = vcount_w'(v);
        hsync  = 1'b1;
        for (int c = 0; c < hsync_cycles; c++) begin
            @(negedge clk);
            for (int s = 0; s < used; s++) begin
                if (gfx_addr == exp_addr[s]) seen[s] = 1'b1;
            end
        end
        hsync = 1'b0;
        for (int i = 0; i < span + 2; i++) begin
            hcount = (i < span) ? hcount_w'(i) : '1;
            if (i >= 2) begin                          // Colour lags hcount by two edges
                exp_color = expected_color(v, i - 2);
                checks++;
                assert (pixel_color == exp_color) else begin
                    $display("CHECK FAILED: pixel_color line %0d hcount %0d expected %h got %h",
                             v, i - 2, exp_color, pixel_color);
                    test_errors++;
                end
            end
            @(negedge clk);
        end
        for (int s = 0; s < used; s++) begin
            assert (seen[s]) else begin
                $display("Line %0d never fetched graphics address %h for slot %0d",
                         v, exp_addr[s], s);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %-10s errors %0d", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        hcount      = '1;
        vcount      = '0;
        vblank      = 1'b0;
        hsync       = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        void'($urandom(32'h6a0c));
        for (int a = 0; a < (1 << gfx_addr_w); a++) begin
            gfx_mem[a] = 32'(a) * 32'h9e37_79b1 + 32'h5bd1_e995;
        end
        for (int a = 0; a < oam_words; a++) oam_mem[a] = '0;
        for (int i = 0; i < num_colors; i++) pal_mem[i] = '0;
        clear_sprites();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        run_vblank();
        run_line(100);
        finish_test("background");

        place_sprite(3, 20, 95, 5, 1'b1, 1'b0, 1'b0);
        run_vblank();
        run_line(100);
        finish_test("colour");

        clear_sprites();
        place_sprite(0, 10, 90, 9, 1'b0, 1'b1, 1'b0);
        place_sprite(1, 40, 96, 12, 1'b1, 1'b0, 1'b1);
        run_vblank();
        run_line(100);
        run_line(103);
        finish_test("flips");

        clear_sprites();
        place_sprite(2, 20, 100, 3, 1'b0, 1'b0, 1'b0);
        place_sprite(6, 28, 98, 4, 1'b1, 1'b0, 1'b0);    // Overlaps sprite 2 from x 28
        run_vblank();
        run_line(105);
        finish_test("priority");

        clear_sprites();
        for (int n = 0; n < 10; n++) place_sprite(n, 6 * n, 92 + n, 20 + n, n[0], 1'b0, 1'b0);
        run_vblank();
        run_line(104);
        finish_test("slot_limit");

        $display("tests %0d, pixel checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- ppu.f
common/ppu_geom_pkg.sv
common/ppu_mem_pkg.sv
sprite_engine/oam_cache.sv
sprite_engine/line_builder.sv
sprite_engine/sprite_slot.sv
rtl/pixel_mixer.sv
rtl/ppu_top.sv
test/ppu_chk.sv
test/ppu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the sprite PPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal --top-module ppu_tb -f ppu.f -o ppu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ppu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$log"; then
    exit 0
fi
exit 1
